/* source/rv32i_pkg.sv */
package rv32i_pkg;

    localparam int xlen       = 32;
    localparam int imem_words = 256;  // instruction ROM depth in words

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    ////////////////////////////////////////////////////////////////////////////
    // major opcodes, taken from instr[6:0]
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        opc_load     = 7'b0000011,
        opc_misc_mem = 7'b0001111,
        opc_op_imm   = 7'b0010011,
        opc_auipc    = 7'b0010111,
        opc_store    = 7'b0100011,
        opc_op       = 7'b0110011,
        opc_lui      = 7'b0110111,
        opc_branch   = 7'b1100011,
        opc_jalr     = 7'b1100111,
        opc_jal      = 7'b1101111,
        opc_system   = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b  // used by LUI
    } alu_op_e;

    typedef enum logic {src_a_rs1, src_a_pc} src_a_sel_e;
    typedef enum logic {src_b_rs2, src_b_imm} src_b_sel_e;
    typedef enum logic [1:0] {wb_alu, wb_load, wb_pc4} wb_sel_e;

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // load and store widths, word access falls to the default
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;

endpackage

/* source/decode_if.sv */
`timescale 1ns/100ps

interface decode_if;
    import rv32i_pkg::*;

    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm;
    alu_op_e         alu_op;
    src_a_sel_e      src_a_sel;
    src_b_sel_e      src_b_sel;
    wb_sel_e         wb_sel;
    logic            rf_write;
    logic            mem_read;
    logic            mem_write;
    logic            branch;    // conditional branch, condition resolved in the alu
    logic            jump_reg;  // JALR, target comes from the alu result
    logic            jump;      // JAL, target is pc + imm

    modport decoder (
        output rs1, rs2, rd, funct3, imm, alu_op,
        output src_a_sel, src_b_sel, wb_sel,
        output rf_write, mem_read, mem_write, branch, jump_reg, jump
    );

    modport datapath (
        input rs1, rs2, rd, funct3, imm, alu_op,
        input src_a_sel, src_b_sel, wb_sel,
        input rf_write, mem_read, mem_write, branch, jump_reg, jump
    );

endinterface

/* source/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       taken,
    input  logic                       jump_reg,
    input  logic [rv32i_pkg::xlen-1:0] alu_result,
    input  logic [rv32i_pkg::xlen-1:0] imm,
    output logic [rv32i_pkg::xlen-1:0] pc,
    output logic [rv32i_pkg::xlen-1:0] pc_plus_4,
    output logic [rv32i_pkg::xlen-1:0] instr
);
    import rv32i_pkg::*;

    logic [xlen-1:0] rom [imem_words];
    logic [xlen-1:0] branch_target;
    logic [xlen-1:0] next_pc;

    initial begin
        $readmemh("program.hex", rom);
    end

    assign pc_plus_4     = pc + 32'd4;
    assign branch_target = pc + imm;  // shared by JAL and taken branches
    assign instr         = rom[pc[$clog2(imem_words)+1:2]];

    always_comb begin
        if (jump_reg) begin
            next_pc = {alu_result[xlen-1:1], 1'b0};  // JALR drops bit 0 of the target
        end else if (taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus_4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= next_pc;
        end
    end

    // a JALR target with bit 1 set or an odd immediate would land here
    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("fetch_unit: pc %h is not word aligned", pc);

endmodule

/* source/decode_unit.sv */
`timescale 1ns/100ps

module decode_unit (
    input  logic [rv32i_pkg::xlen-1:0] instr,
    input  logic                       rst_n,
    decode_if.decoder                  dec
);
    import rv32i_pkg::*;

    opcode_e         opcode;
    logic            funct7_5;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    // funct3 to alu operation, alt picks SUB or SRA where the encoding allows it
    function automatic alu_op_e alu_ctrl(input logic [2:0] f3, input logic alt,
                                         input logic is_reg);
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt && is_reg) ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode   = opcode_e'(instr[6:0]);
    assign funct7_5 = instr[30];

    assign dec.rs1    = instr[19:15];
    assign dec.rs2    = instr[24:20];
    assign dec.rd     = instr[11:7];
    assign dec.funct3 = instr[14:12];

    ////////////////////////////////////////////////////////////////////////////
    // immediate formats
    ////////////////////////////////////////////////////////////////////////////
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    ////////////////////////////////////////////////////////////////////////////
    // main control
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        dec.imm       = imm_i;
        dec.alu_op    = alu_add;
        dec.src_a_sel = src_a_rs1;
        dec.src_b_sel = src_b_imm;
        dec.wb_sel    = wb_alu;
        dec.rf_write  = 1'b0;
        dec.mem_read  = 1'b0;
        dec.mem_write = 1'b0;
        dec.branch    = 1'b0;
        dec.jump_reg  = 1'b0;
        dec.jump      = 1'b0;

        case (opcode)
            opc_lui: begin
                dec.imm      = imm_u;
                dec.alu_op   = alu_pass_b;
                dec.rf_write = 1'b1;
            end
            opc_auipc: begin
                dec.imm       = imm_u;
                dec.src_a_sel = src_a_pc;
                dec.rf_write  = 1'b1;
            end
            opc_jal: begin
                dec.imm      = imm_j;
                dec.wb_sel   = wb_pc4;
                dec.rf_write = 1'b1;
                dec.jump     = 1'b1;
            end
            opc_jalr: begin
                dec.wb_sel   = wb_pc4;
                dec.rf_write = 1'b1;
                dec.jump_reg = 1'b1;
            end
            opc_branch: begin
                dec.imm       = imm_b;
                dec.src_b_sel = src_b_rs2;  // compare rs1 against rs2
                dec.branch    = 1'b1;
            end
            opc_load: begin
                dec.wb_sel   = wb_load;
                dec.rf_write = 1'b1;
                dec.mem_read = 1'b1;
            end
            opc_store: begin
                dec.imm       = imm_s;
                dec.mem_write = 1'b1;
            end
            opc_op_imm: begin
                dec.alu_op   = alu_ctrl(dec.funct3, imm_i[10], 1'b0);  // imm bit 10 marks SRAI
                dec.rf_write = 1'b1;
            end
            opc_op: begin
                dec.alu_op    = alu_ctrl(dec.funct3, funct7_5, 1'b1);
                dec.src_b_sel = src_b_rs2;
                dec.rf_write  = 1'b1;
            end
            default: begin
                // FENCE, ECALL, EBREAK and CSR accesses retire as no-ops
            end
        endcase

        if (!rst_n) begin
            dec.rf_write  = 1'b0;
            dec.mem_read  = 1'b0;
            dec.mem_write = 1'b0;
            dec.branch    = 1'b0;
            dec.jump_reg  = 1'b0;
            dec.jump      = 1'b0;
        end
    end

endmodule

/* source/register_file.sv */
`timescale 1ns/100ps

module register_file (
    input  logic                       clk,
    decode_if.datapath                 dp,
    input  logic [rv32i_pkg::xlen-1:0] write_data,
    output logic [rv32i_pkg::xlen-1:0] read_data1,
    output logic [rv32i_pkg::xlen-1:0] read_data2
);
    import rv32i_pkg::*;

    logic [xlen-1:0] regs [32];

    // writes to x0 are dropped here
    always_ff @(posedge clk) begin
        if (dp.rf_write && dp.rd != 5'd0) begin
            regs[dp.rd] <= write_data;
        end
    end

    assign read_data1 = (dp.rs1 == 5'd0) ? '0 : regs[dp.rs1];
    assign read_data2 = (dp.rs2 == 5'd0) ? '0 : regs[dp.rs2];

endmodule

/* source/alu.sv */
`timescale 1ns/100ps

module alu (
    input  logic [rv32i_pkg::xlen-1:0] src_a,
    input  logic [rv32i_pkg::xlen-1:0] src_b,
    decode_if.datapath                 dp,
    output logic [rv32i_pkg::xlen-1:0] result,
    output logic                       taken
);
    import rv32i_pkg::*;

    logic [4:0] shamt;
    logic       branch_cond;

    assign shamt = src_b[4:0];

    always_comb begin
        case (dp.alu_op)
            alu_sub:    result = src_a - src_b;
            alu_sll:    result = src_a << shamt;
            alu_slt:    result = {31'b0, $signed(src_a) < $signed(src_b)};
            alu_sltu:   result = {31'b0, src_a < src_b};
            alu_xor:    result = src_a ^ src_b;
            alu_srl:    result = src_a >> shamt;
            alu_sra:    result = $unsigned($signed(src_a) >>> shamt);
            alu_or:     result = src_a | src_b;
            alu_and:    result = src_a & src_b;
            alu_pass_b: result = src_b;
            default:    result = src_a + src_b;
        endcase
    end

    // compare straight on the operands, the result path stays free for the target
    always_comb begin
        case (dp.funct3)
            f3_beq:  branch_cond = (src_a == src_b);
            f3_bne:  branch_cond = (src_a != src_b);
            f3_blt:  branch_cond = ($signed(src_a) < $signed(src_b));
            f3_bge:  branch_cond = ($signed(src_a) >= $signed(src_b));
            f3_bltu: branch_cond = (src_a < src_b);
            f3_bgeu: branch_cond = (src_a >= src_b);
            default: branch_cond = 1'b0;
        endcase
    end

    assign taken = (dp.branch && branch_cond) || dp.jump;

endmodule

/* source/load_store_unit.sv */
`timescale 1ns/100ps

module load_store_unit (
    decode_if.datapath                 dp,
    input  logic [rv32i_pkg::xlen-1:0] address,
    input  logic [rv32i_pkg::xlen-1:0] store_data,
    input  logic [rv32i_pkg::xlen-1:0] data_memory_read_data,
    output logic [rv32i_pkg::xlen-1:0] load_data,
    output logic [rv32i_pkg::xlen-1:0] data_memory_write_data,
    output logic [3:0]                 write_mask,
    output logic                       memory_read,
    output logic                       memory_write
);
    import rv32i_pkg::*;

    logic [1:0]  offset;
    logic [3:0]  lane_mask;
    logic [7:0]  load_byte;
    logic [15:0] load_half;

    assign offset       = address[1:0];
    assign memory_read  = dp.mem_read;
    assign memory_write = dp.mem_write;

    // narrow stores are copied to every lane and the mask picks the right one
    always_comb begin
        case (dp.funct3)
            f3_sb: begin
                data_memory_write_data = {4{store_data[7:0]}};
                lane_mask              = 4'b0001 << offset;
            end
            f3_sh: begin
                data_memory_write_data = {2{store_data[15:0]}};
                lane_mask              = offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                data_memory_write_data = store_data;
                lane_mask              = 4'b1111;
            end
        endcase
    end

    assign write_mask = dp.mem_write ? lane_mask : 4'b0000;

    assign load_byte = data_memory_read_data[8*offset +: 8];
    assign load_half = offset[1] ? data_memory_read_data[31:16] : data_memory_read_data[15:0];

    always_comb begin
        case (dp.funct3)
            f3_lb:   load_data = {{24{load_byte[7]}}, load_byte};
            f3_lbu:  load_data = {24'b0, load_byte};
            f3_lh:   load_data = {{16{load_half[15]}}, load_half};
            f3_lhu:  load_data = {16'b0, load_half};
            default: load_data = data_memory_read_data;
        endcase
    end

endmodule

/* source/rv32i_core.sv */
`timescale 1ns/100ps

module rv32i_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [rv32i_pkg::xlen-1:0] data_memory_read_data,
    output logic                       memory_read,
    output logic                       memory_write,
    output logic [rv32i_pkg::xlen-1:0] data_memory_write_data,
    output logic [3:0]                 write_mask,
    output logic [rv32i_pkg::xlen-1:0] data_memory_address
);
    import rv32i_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus_4;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] read_data1;
    logic [xlen-1:0] read_data2;
    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] wb_data;
    logic            taken;

    decode_if dec ();

    ////////////////////////////////////////////////////////////////////////////
    // fetch and decode
    ////////////////////////////////////////////////////////////////////////////
    fetch_unit u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .taken      (taken),
        .jump_reg   (dec.jump_reg),
        .alu_result (alu_result),
        .imm        (dec.imm),
        .pc         (pc),
        .pc_plus_4  (pc_plus_4),
        .instr      (instr)
    );

    decode_unit u_decode (
        .instr (instr),
        .rst_n (rst_n),
        .dec   (dec.decoder)
    );

    ////////////////////////////////////////////////////////////////////////////
    // execute, memory and write back
    ////////////////////////////////////////////////////////////////////////////
    register_file u_regs (
        .clk        (clk),
        .dp         (dec.datapath),
        .write_data (wb_data),
        .read_data1 (read_data1),
        .read_data2 (read_data2)
    );

    assign src_a = (dec.src_a_sel == src_a_pc) ? pc : read_data1;    // AUIPC takes the pc
    assign src_b = (dec.src_b_sel == src_b_imm) ? dec.imm : read_data2;

    alu u_alu (
        .src_a  (src_a),
        .src_b  (src_b),
        .dp     (dec.datapath),
        .result (alu_result),
        .taken  (taken)
    );

    assign data_memory_address = alu_result;

    load_store_unit u_lsu (
        .dp                     (dec.datapath),
        .address                (alu_result),
        .store_data             (read_data2),
        .data_memory_read_data  (data_memory_read_data),
        .load_data              (load_data),
        .data_memory_write_data (data_memory_write_data),
        .write_mask             (write_mask),
        .memory_read            (memory_read),
        .memory_write           (memory_write)
    );

    always_comb begin
        case (dec.wb_sel)
            wb_alu:  wb_data = alu_result;
            wb_load: wb_data = load_data;
            wb_pc4:  wb_data = pc_plus_4;  // link value for JAL and JALR
            default: wb_data = '0;
        endcase
    end

    // misaligned accesses are not trapped, so halfwords and words must sit on their boundary
    assert property (@(posedge clk) disable iff (!rst_n)
        (memory_read || memory_write) |->
            (dec.funct3[1:0] == 2'b00) ||
            (dec.funct3[1:0] == 2'b01 && !data_memory_address[0]) ||
            (data_memory_address[1:0] == 2'b00))
        else $error("rv32i_core: misaligned access to %h", data_memory_address);

endmodule

/* testbench/tb_rv32i_core.sv */
`timescale 1ns/100ps

module tb_rv32i_core;
    import rv32i_pkg::*;

    localparam logic [31:0] halt_addr   = 32'h0000_0ffc;
    localparam int          dmem_words  = 1024;
    localparam int          run_timeout = 2000;  // cycles allowed until the halt store

    logic        clk;
    logic        rst_n;
    logic [31:0] data_memory_read_data;
    logic        memory_read;
    logic        memory_write;
    logic [31:0] data_memory_write_data;
    logic [3:0]  write_mask;
    logic [31:0] data_memory_address;

    logic [31:0] dmem [dmem_words];
    logic [31:0] model_mem [dmem_words];
    logic [31:0] model_regs [32];
    logic [31:0] prog [imem_words];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_mask [$];

    int errors;
    int store_idx;
    int load_count;
    int exp_loads;
    bit halt_seen;

    rv32i_core dut (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .data_memory_read_data  (data_memory_read_data),
        .memory_read            (memory_read),
        .memory_write           (memory_write),
        .data_memory_write_data (data_memory_write_data),
        .write_mask             (write_mask),
        .data_memory_address    (data_memory_address)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    function automatic logic [31:0] fill_word(input int i);
        return (i * 32'h9e37_79b9) ^ (i << 16);  // every word differs across the whole range
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // data memory, combinational read and masked write at the clock edge
    ////////////////////////////////////////////////////////////////////////////
    assign data_memory_read_data = dmem[data_memory_address[11:2]];

    always @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            if (rst_n && memory_write && write_mask[k]) begin
                dmem[data_memory_address[11:2]][8*k +: 8] <= data_memory_write_data[8*k +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // instruction-set model, returns the number of expected stores and counts loads
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic int run_model();
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] w;
        logic [31:0] sdata;
        logic [3:0]  smask;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        cond;
        pc = reset_pc;
        for (int step = 0; step < run_timeout; step++) begin
            ins   = prog[pc[9:2]];
            rd    = ins[11:7];
            f3    = ins[14:12];
            a     = model_regs[ins[19:15]];
            b     = model_regs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            npc   = pc + 32'd4;
            case (opcode_e'(ins[6:0]))
                opc_lui:    model_regs[rd] = {ins[31:12], 12'b0};
                opc_auipc:  model_regs[rd] = pc + {ins[31:12], 12'b0};
                opc_jal: begin
                    model_regs[rd] = pc + 32'd4;
                    npc = pc + imm_j;
                end
                opc_jalr: begin
                    npc = (a + imm_i) & ~32'd1;
                    model_regs[rd] = pc + 32'd4;
                end
                opc_branch: begin
                    case (f3)
                        3'd0:    cond = (a == b);
                        3'd1:    cond = (a != b);
                        3'd4:    cond = ($signed(a) < $signed(b));
                        3'd5:    cond = ($signed(a) >= $signed(b));
                        3'd6:    cond = (a < b);
                        default: cond = (a >= b);
                    endcase
                    if (cond) npc = pc + imm_b;
                end
                opc_load: begin
                    exp_loads++;
                    addr = a + imm_i;
                    w = model_mem[addr[11:2]];
                    case (f3)
                        3'd0: model_regs[rd] = {{24{w[8*addr[1:0]+7]}}, w[8*addr[1:0] +: 8]};
                        3'd4: model_regs[rd] = {24'b0, w[8*addr[1:0] +: 8]};
                        3'd1: model_regs[rd] = {{16{w[16*addr[1]+15]}}, w[16*addr[1] +: 16]};
                        3'd5: model_regs[rd] = {16'b0, w[16*addr[1] +: 16]};
                        default: model_regs[rd] = w;
                    endcase
                end
                opc_store: begin
                    addr = a + imm_s;
                    case (f3)
                        3'd0: begin
                            sdata = {4{b[7:0]}};
                            smask = 4'b0001 << addr[1:0];
                        end
                        3'd1: begin
                            sdata = {2{b[15:0]}};
                            smask = addr[1] ? 4'b1100 : 4'b0011;
                        end
                        default: begin
                            sdata = b;
                            smask = 4'b1111;
                        end
                    endcase
                    for (int k = 0; k < 4; k++) begin
                        if (smask[k]) model_mem[addr[11:2]][8*k +: 8] = sdata[8*k +: 8];
                    end
                    exp_addr.push_back(addr);
                    exp_data.push_back(sdata);
                    exp_mask.push_back(smask);
                    if (addr == halt_addr) return exp_addr.size();
                end
                opc_op_imm: model_regs[rd] = alu_ref(f3, (f3 == 3'd5) && ins[30], a, imm_i);
                opc_op:     model_regs[rd] = alu_ref(f3, ins[30], a, b);
                default: ;  // fence and system do nothing
            endcase
            model_regs[0] = 32'd0;
            pc = npc;
        end
        return exp_addr.size();
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // store comparison
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (!rst_n) begin
            check_value("memory_read", {31'b0, memory_read}, 32'd0);
            check_value("memory_write", {31'b0, memory_write}, 32'd0);
        end else if (!halt_seen) begin
            if (memory_read) begin
                load_count++;
            end
            if (memory_write) begin
                if (store_idx >= exp_addr.size()) begin
                    $display("Error at %0t: the core made a store the model does not expect",
                             $time);
                    errors++;
                end else begin
                    check_value("data_memory_address", data_memory_address,
                                exp_addr[store_idx]);
                    check_value("data_memory_write_data", data_memory_write_data,
                                exp_data[store_idx]);
                    check_value("write_mask", {28'b0, write_mask},
                                {28'b0, exp_mask[store_idx]});
                    if (exp_addr[store_idx] == halt_addr) halt_seen = 1'b1;
                    store_idx++;
                end
            end
        end
    end

    initial begin
        int expected_stores;
        int cycles;
        errors     = 0;
        store_idx  = 0;
        load_count = 0;
        exp_loads  = 0;
        halt_seen  = 1'b0;
        rst_n      = 1'b0;
        $readmemh("program.hex", prog);
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i]      = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) model_regs[i] = 32'd0;
        expected_stores = run_model();

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        cycles = 0;
        while (!halt_seen && cycles < run_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!halt_seen) begin
            $display("Timeout: the halt store never arrived within %0d cycles", run_timeout);
            errors++;
        end
        check_value("store_count", store_idx, expected_stores);
        check_value("load_count", load_count, exp_loads);
        for (int i = 0; i < dmem_words; i++) begin
            check_value($sformatf("dmem[%0d]", i), dmem[i], model_mem[i]);
        end

        $display("stores: %0d  loads: %0d  errors: %0d", store_idx, load_count, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* program.hex */
// one 32-bit instruction per line, word 0 is fetched first
ff900093
00300113
402081b3
20302023
4020d233
20402223
41f0d293
20502423
0020a333
0020b3b3
01f11413
01f0d493
20602623
20702823
20802a23
20902c23
10100503
10205583
10601603
10304683
10402703
20a02e23
22b02023
22c02223
22d02423
22e02623
221008a3
22101b23
123457b7
00001817
00508013
22f02c23
23002e23
24002023
00108463
24102223
00109463
24202423
0020c463
24102223
0020e463
24302623
00115463
24102223
00117463
24402823
008008ef
24102223
25102a23
01188967
24102223
25202c23
000012b7
fe02ae23
0000006f

/* verilog.f */
source/rv32i_pkg.sv
source/decode_if.sv
source/fetch_unit.sv
source/decode_unit.sv
source/register_file.sv
source/alu.sv
source/load_store_unit.sv
source/rv32i_core.sv
testbench/tb_rv32i_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_rv32i_core -o sim_rv32i
./obj_dir/sim_rv32i | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
exit 0
